/* except_pkg.sv */
// ****************************************
// except_pkg
// sizes, report structs and the event word
// shared by the banked event RAM.
// ****************************************

package except_pkg;

  localparam int num_banks = 4;  // entries per row.
  localparam int bank_bits = 2;
  localparam int num_rows  = 16;  // rows in the window.
  localparam int row_bits  = 4;
  localparam int num_wr    = 3;  // execution write ports.
  localparam int word_bits = 16;

  localparam logic [1:0] kind_none   = 2'd0;
  localparam logic [1:0] kind_fault  = 2'd1;
  localparam logic [1:0] kind_branch = 2'd2;

  // ****************************************
  // event word, two views over one entry
  // ****************************************

  typedef struct packed {
    logic [1:0] kind;
    logic [4:0] cause;
    logic [8:0] addr_lo;
  } fault_t;

  typedef struct packed {
    logic [1:0]           kind;
    logic [word_bits-3:0] target;  // full redirect target.
  } branch_t;

  typedef union packed {
    fault_t  fault;
    branch_t branch;
  } except_word_u;

  // ****************************************
  // addresses and reports
  // ****************************************

  typedef struct packed {
    logic [row_bits-1:0]  row;
    logic [bank_bits-1:0] bank;
  } entry_addr_t;

  typedef struct packed {
    logic                 valid;
    entry_addr_t          entry;
    logic [1:0]           kind;
    logic [word_bits-3:0] payload;  // cause and addr_lo, or target.
  } exec_report_t;

  typedef struct packed {
    logic         wen;
    entry_addr_t  entry;
    except_word_u data;
  } bank_wr_t;

  typedef struct packed {
    logic                 valid;
    logic                 has_event;
    logic [bank_bits-1:0] bank;
    logic [1:0]           kind;
    logic [4:0]           cause;
    logic [word_bits-3:0] target;
  } retire_result_t;

endpackage

/* except_bank.sv */
// ****************************************
// except_bank
// one bank of the event RAM: three entry
// write ports, a row clear, registered read.
// ****************************************

`timescale 1ns/100ps

module except_bank (
  input  logic                                clk,
  input  logic                                rst_n,
  input  except_pkg::bank_wr_t                wr_port [except_pkg::num_wr],
  input  logic                                clr,
  input  logic [except_pkg::row_bits-1:0]     clr_row,
  input  logic                                read_step,
  input  logic [except_pkg::row_bits-1:0]     read_row,
  output except_pkg::except_word_u            read_data
);

  except_pkg::except_word_u mem [except_pkg::num_rows];

  logic [except_pkg::row_bits-1:0] read_row_q;

  // ****************************************
  // writes
  // ****************************************

  // port order gives priority, highest port last.
  // the clear comes after all ports so it wins on its row.
  always_ff @(posedge clk) begin
    for (int i = 0; i < except_pkg::num_wr; i++) begin
      if (wr_port[i].wen) begin
        mem[wr_port[i].entry.row] <= wr_port[i].data;
      end
    end
    if (clr) begin
      mem[clr_row] <= {except_pkg::kind_none, {(except_pkg::word_bits-2){1'b0}}};
    end
  end

  // ****************************************
  // read
  // ****************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      read_row_q <= '0;
    end else if (read_step) begin
      read_row_q <= read_row;  // hold until the next step.
    end
  end

  assign read_data = mem[read_row_q];  // sees writes of the same edge.

endmodule

/* except_ram.sv */
// ****************************************
// except_ram
// array of event banks; routes writes by
// bank field and gathers one row per read.
// ****************************************

`timescale 1ns/100ps

module except_ram (
  input  logic                                clk,
  input  logic                                rst_n,
  input  except_pkg::bank_wr_t                wr_port [except_pkg::num_wr],
  input  logic                                clr,
  input  logic [except_pkg::row_bits-1:0]     clr_row,
  input  logic                                read_step,
  input  logic [except_pkg::row_bits-1:0]     read_row,
  output except_pkg::except_word_u            row_data [except_pkg::num_banks]
);

  for (genvar b = 0; b < except_pkg::num_banks; b++) begin : g_bank

    except_pkg::bank_wr_t bank_wr [except_pkg::num_wr];

    // a port writes this bank only when its bank field matches.
    always_comb begin
      for (int i = 0; i < except_pkg::num_wr; i++) begin
        bank_wr[i]     = wr_port[i];
        bank_wr[i].wen = wr_port[i].wen &&
                         (wr_port[i].entry.bank == (except_pkg::bank_bits)'(b));
      end
    end

    // row clear goes to every bank at once.
    except_bank u_bank (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_port   (bank_wr),
      .clr       (clr),
      .clr_row   (clr_row),
      .read_step (read_step),
      .read_row  (read_row),
      .read_data (row_data[b])
    );

  end

endmodule

/* except_writeback.sv */
// ****************************************
// except_writeback
// registers execution reports as event
// words and turns allocs into row clears.
// ****************************************

`timescale 1ns/100ps

module except_writeback (
  input  logic                                clk,
  input  logic                                rst_n,
  input  except_pkg::exec_report_t            report [except_pkg::num_wr],
  input  logic                                alloc,
  input  logic [except_pkg::row_bits-1:0]     alloc_row,
  output except_pkg::bank_wr_t                wr_port [except_pkg::num_wr],
  output logic                                clr,
  output logic [except_pkg::row_bits-1:0]     clr_row
);

  except_pkg::except_word_u word_d  [except_pkg::num_wr];
  logic                     keep_d  [except_pkg::num_wr];
  logic                     wen_q   [except_pkg::num_wr];
  except_pkg::entry_addr_t  entry_q [except_pkg::num_wr];
  except_pkg::except_word_u data_q  [except_pkg::num_wr];

  // ****************************************
  // event word build
  // ****************************************

  always_comb begin
    for (int i = 0; i < except_pkg::num_wr; i++) begin
      word_d[i] = '0;
      case (report[i].kind)
        except_pkg::kind_fault: begin
          word_d[i].fault.kind    = except_pkg::kind_fault;
          word_d[i].fault.cause   = report[i].payload[13:9];
          word_d[i].fault.addr_lo = report[i].payload[8:0];
        end
        except_pkg::kind_branch: begin
          word_d[i].branch.kind   = except_pkg::kind_branch;
          word_d[i].branch.target = report[i].payload;
        end
        default: word_d[i].fault.kind = except_pkg::kind_none;
      endcase
      // a report to a row being allocated is from a squashed instruction.
      keep_d[i] = report[i].valid &&
                  !(alloc && (report[i].entry.row == alloc_row));
    end
  end

  // ****************************************
  // registers
  // ****************************************

  always_ff @(posedge clk) begin
    for (int i = 0; i < except_pkg::num_wr; i++) begin
      wen_q[i] <= rst_n && keep_d[i];
    end
    clr <= rst_n && alloc;
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < except_pkg::num_wr; i++) begin
      entry_q[i] <= report[i].entry;
      data_q[i]  <= word_d[i];
    end
    clr_row <= alloc_row;
  end

  always_comb begin
    for (int i = 0; i < except_pkg::num_wr; i++) begin
      wr_port[i].wen   = wen_q[i];
      wr_port[i].entry = entry_q[i];
      wr_port[i].data  = data_q[i];
    end
  end

endmodule

/* except_retire.sv */
// ****************************************
// except_retire
// reads a row per retire step and reports
// the oldest event with cause or target.
// ****************************************

`timescale 1ns/100ps

module except_retire (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                retire_step,
  input  logic [except_pkg::row_bits-1:0]     retire_row,
  input  except_pkg::except_word_u            row_data [except_pkg::num_banks],
  output logic                                read_step,
  output logic [except_pkg::row_bits-1:0]     read_row,
  output except_pkg::retire_result_t          result
);

  logic                               step_q;
  logic                               hit;
  logic [except_pkg::bank_bits-1:0]   hit_bank;
  except_pkg::except_word_u           hit_word;
  except_pkg::retire_result_t         res_d;
  except_pkg::retire_result_t         res_q;
  logic                               valid_q;

  // the bank registers the row on this step.
  assign read_step = retire_step;
  assign read_row  = retire_row;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step_q <= 1'b0;
    end else begin
      step_q <= retire_step;  // row data valid this cycle.
    end
  end

  // ****************************************
  // oldest event scan
  // ****************************************

  always_comb begin
    hit      = 1'b0;
    hit_bank = '0;
    hit_word = '0;
    for (int b = 0; b < except_pkg::num_banks; b++) begin
      if (!hit && (row_data[b].fault.kind != except_pkg::kind_none)) begin
        hit      = 1'b1;
        hit_bank = (except_pkg::bank_bits)'(b);  // lowest bank is oldest.
        hit_word = row_data[b];
      end
    end
  end

  always_comb begin
    res_d           = '0;
    res_d.valid     = step_q;
    res_d.has_event = hit;
    res_d.bank      = hit_bank;
    res_d.kind      = hit_word.fault.kind;  // same bits in both views.
    if (hit_word.fault.kind == except_pkg::kind_fault) begin
      res_d.cause = hit_word.fault.cause;
    end else if (hit_word.branch.kind == except_pkg::kind_branch) begin
      res_d.target = hit_word.branch.target;
    end
  end

  // ****************************************
  // result register
  // ****************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= step_q;
    end
  end

  always_ff @(posedge clk) begin
    if (step_q) begin
      res_q <= res_d;
    end
  end

  always_comb begin
    result       = res_q;
    result.valid = valid_q;  // one-cycle pulse.
  end

endmodule

/* except_top.sv */
// ****************************************
// except_top
// event record subsystem: writeback, banked
// RAM and retire read side.
// ****************************************

`timescale 1ns/100ps

module except_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  except_pkg::exec_report_t            report [except_pkg::num_wr],
  input  logic                                alloc,
  input  logic [except_pkg::row_bits-1:0]     alloc_row,
  input  logic                                retire_step,
  input  logic [except_pkg::row_bits-1:0]     retire_row,
  output except_pkg::retire_result_t          result
);

  except_pkg::bank_wr_t            wr_port  [except_pkg::num_wr];
  logic                            clr;
  logic [except_pkg::row_bits-1:0] clr_row;
  logic                            read_step;
  logic [except_pkg::row_bits-1:0] read_row;
  except_pkg::except_word_u        row_data [except_pkg::num_banks];

  except_writeback u_writeback (
    .clk       (clk),
    .rst_n     (rst_n),
    .report    (report),
    .alloc     (alloc),
    .alloc_row (alloc_row),
    .wr_port   (wr_port),
    .clr       (clr),
    .clr_row   (clr_row)
  );

  except_ram u_ram (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_port   (wr_port),
    .clr       (clr),
    .clr_row   (clr_row),
    .read_step (read_step),
    .read_row  (read_row),
    .row_data  (row_data)
  );

  except_retire u_retire (
    .clk         (clk),
    .rst_n       (rst_n),
    .retire_step (retire_step),
    .retire_row  (retire_row),
    .row_data    (row_data),
    .read_step   (read_step),
    .read_row    (read_row),
    .result      (result)
  );

endmodule

/* tb_clock.sv */
// ****************************************
// tb_clock
// 4 ns clock, reset low for 4 cycles.
// ****************************************

`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* tb_except.sv */
// ****************************************
// tb_except
// table driven testbench for the event RAM.
// ****************************************

`timescale 1ns/100ps

module tb_except;

  localparam int kn = 0;
  localparam int kf = 1;
  localparam int kb = 2;
  localparam int num_vec = 20;

  typedef struct packed {
    logic       valid;
    logic [3:0] row;
    logic [1:0] bank;
    logic [1:0] kind;
  } slot_t;

  typedef struct packed {
    slot_t [2:0] rep;
    logic        alloc;
    logic [3:0]  alloc_row;
    logic        step;
    logic [3:0]  step_row;
    logic        back;  // no idle gap before this row.
    logic        exp_event;
    logic [1:0]  exp_bank;
    logic [1:0]  exp_kind;
  } vec_t;

  localparam slot_t no_rep = '0;

  logic                       clk;
  logic                       rst_n;
  except_pkg::exec_report_t   report [except_pkg::num_wr];
  logic                       alloc;
  logic [3:0]                 alloc_row;
  logic                       retire_step;
  logic [3:0]                 retire_row;
  except_pkg::retire_result_t result;

  vec_t        tab [num_vec];
  int          seed = 32'h315a;
  int          cyc = 0;
  logic        drv_done = 1'b0;
  logic [1:0]  m_kind [except_pkg::num_rows][except_pkg::num_banks];
  logic [13:0] m_pay  [except_pkg::num_rows][except_pkg::num_banks];

  except_pkg::retire_result_t exp_q [$];
  int                         at_q  [$];
  int                         idx_q [$];

  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  except_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .report      (report),
    .alloc       (alloc),
    .alloc_row   (alloc_row),
    .retire_step (retire_step),
    .retire_row  (retire_row),
    .result      (result)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // ****************************************
  // helpers
  // ****************************************

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      abort_run($sformatf("ERR %0t %s got %0h exp %0h", $time, name, got, want));
    end
  endtask

  function automatic slot_t slot(input int r, input int b, input int k);
    slot_t s;
    s.valid = 1'b1;
    s.row   = 4'(r);
    s.bank  = 2'(b);
    s.kind  = 2'(k);
    return s;
  endfunction

  function automatic vec_t row_vec(input slot_t s0, s1, s2, input int alc, arow,
                                   stp, srow, back, ev, bnk, knd);
    vec_t v;
    v.rep[0]    = s0;
    v.rep[1]    = s1;
    v.rep[2]    = s2;
    v.alloc     = (alc != 0);
    v.alloc_row = 4'(arow);
    v.step      = (stp != 0);
    v.step_row  = 4'(srow);
    v.back      = (back != 0);
    v.exp_event = (ev != 0);
    v.exp_bank  = 2'(bnk);
    v.exp_kind  = 2'(knd);
    return v;
  endfunction

  // oldest entry is the lowest bank with an event.
  function automatic except_pkg::retire_result_t expect_result(input logic [3:0] r);
    except_pkg::retire_result_t e;
    e = '0;
    e.valid = 1'b1;
    for (int b = 0; b < except_pkg::num_banks; b++) begin
      if (!e.has_event && m_kind[r][b] != 2'd0) begin
        e.has_event = 1'b1;
        e.bank      = 2'(b);
        e.kind      = m_kind[r][b];
        if (m_kind[r][b] == 2'(kf)) begin
          e.cause = m_pay[r][b][13:9];
        end else begin
          e.target = m_pay[r][b];
        end
      end
    end
    return e;
  endfunction

  task automatic drive_idle();
    except_pkg::exec_report_t rep;
    logic [31:0]              r;
    @(posedge clk);
    for (int i = 0; i < except_pkg::num_wr; i++) begin
      r           = $random(seed);
      rep         = '0;
      rep.payload = r[13:0];  // noise on an invalid slot.
      report[i] <= rep;
    end
    alloc       <= 1'b0;
    retire_step <= 1'b0;
  endtask

  task automatic apply_row(input int idx);
    vec_t                     v;
    except_pkg::exec_report_t rep;
    logic [31:0]              r;
    logic [13:0]              pay [except_pkg::num_wr];
    v = tab[idx];
    @(posedge clk);
    for (int i = 0; i < except_pkg::num_wr; i++) begin
      r      = $random(seed);
      pay[i] = r[13:0];
    end
    // the step reads the row before this row's own writes land.
    if (v.step) begin
      exp_q.push_back(expect_result(v.step_row));
      at_q.push_back(cyc + 1);
      idx_q.push_back(idx);
    end
    for (int i = 0; i < except_pkg::num_wr; i++) begin
      if (v.rep[i].valid && !(v.alloc && v.rep[i].row == v.alloc_row)) begin
        m_kind[v.rep[i].row][v.rep[i].bank] = v.rep[i].kind;
        m_pay[v.rep[i].row][v.rep[i].bank]  = pay[i];
      end
      rep.valid      = v.rep[i].valid;
      rep.entry.row  = v.rep[i].row;
      rep.entry.bank = v.rep[i].bank;
      rep.kind       = v.rep[i].kind;
      rep.payload    = pay[i];
      report[i] <= rep;
    end
    if (v.alloc) begin
      for (int b = 0; b < except_pkg::num_banks; b++) begin
        m_kind[v.alloc_row][b] = 2'd0;
      end
    end
    alloc       <= v.alloc;
    alloc_row   <= v.alloc_row;
    retire_step <= v.step;
    retire_row  <= v.step_row;
  endtask

  // ****************************************
  // stimulus
  // ****************************************

  initial begin : driver
    int          waited;
    logic [31:0] r;
    for (int i = 0; i < except_pkg::num_wr; i++) begin
      report[i] <= '0;
    end
    alloc       <= 1'b0;
    alloc_row   <= '0;
    retire_step <= 1'b0;
    retire_row  <= '0;
    for (int i = 0; i < except_pkg::num_rows; i++) begin
      for (int b = 0; b < except_pkg::num_banks; b++) begin
        m_kind[i][b] = 2'd0;
        m_pay[i][b]  = '0;
      end
    end
    //                slots 0..2                   alloc  step   back  event bank kind
    tab[0]  = row_vec(no_rep, no_rep, no_rep,         1, 3, 0, 0, 0, 0, 0, kn);
    tab[1]  = row_vec(no_rep, no_rep, no_rep,         1, 5, 0, 0, 0, 0, 0, kn);
    tab[2]  = row_vec(no_rep, no_rep, no_rep,         1, 7, 0, 0, 0, 0, 0, kn);
    tab[3]  = row_vec(no_rep, no_rep, no_rep,         1, 9, 0, 0, 0, 0, 0, kn);
    tab[4]  = row_vec(no_rep, no_rep, no_rep,         0, 0, 1, 3, 0, 0, 0, kn);
    tab[5]  = row_vec(slot(5, 2, kf), no_rep, no_rep, 0, 0, 0, 0, 0, 0, 0, kn);
    tab[6]  = row_vec(no_rep, no_rep, no_rep,         0, 0, 1, 5, 0, 1, 2, kf);
    tab[7]  = row_vec(no_rep, slot(7, 1, kb), no_rep, 0, 0, 0, 0, 0, 0, 0, kn);
    tab[8]  = row_vec(no_rep, no_rep, no_rep,         0, 0, 1, 7, 0, 1, 1, kb);
    tab[9]  = row_vec(slot(9, 3, kf), slot(9, 1, kf), slot(9, 1, kb),
                      0, 0, 0, 0, 0, 0, 0, kn);
    tab[10] = row_vec(no_rep, no_rep, no_rep,         0, 0, 1, 9, 0, 1, 1, kb);
    tab[11] = row_vec(slot(3, 0, kf), no_rep, no_rep, 0, 0, 0, 0, 0, 0, 0, kn);
    tab[12] = row_vec(no_rep, no_rep, no_rep,         0, 0, 1, 3, 0, 1, 0, kf);
    tab[13] = row_vec(no_rep, slot(3, 2, kb), slot(5, 0, kf),
                      1, 3, 0, 0, 0, 0, 0, kn);
    tab[14] = row_vec(no_rep, no_rep, no_rep,         0, 0, 1, 3, 1, 0, 0, kn);
    tab[15] = row_vec(no_rep, no_rep, no_rep,         0, 0, 1, 5, 1, 1, 0, kf);
    tab[16] = row_vec(no_rep, no_rep, no_rep,         0, 0, 1, 9, 1, 1, 1, kb);
    tab[17] = row_vec(no_rep, no_rep, no_rep,         0, 0, 1, 7, 1, 1, 1, kb);
    tab[18] = row_vec(slot(7, 0, kf), no_rep, no_rep, 0, 0, 1, 7, 1, 1, 1, kb);
    tab[19] = row_vec(no_rep, no_rep, no_rep,         0, 0, 1, 7, 1, 1, 0, kf);
    waited = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      waited++;
      if (waited > 10) abort_run("reset was never released");
    end
    for (int i = 0; i < num_vec; i++) begin
      if (!tab[i].back) begin
        r = $random(seed);
        repeat (r[1:0]) drive_idle();  // random idle gap.
      end
      apply_row(i);
    end
    drive_idle();
    drv_done = 1'b1;
  end

  // ****************************************
  // result checks
  // ****************************************

  initial begin : check_results
    except_pkg::retire_result_t want;
    int                         at;
    int                         idx;
    int                         waited;
    int                         idle;
    waited = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > 10) abort_run("reset was never released");
    end
    idle = 0;
    while (!(drv_done && exp_q.size() == 0)) begin
      if (exp_q.size() == 0) begin
        @(negedge clk);
        idle++;
        assert (result.valid === 1'b0) else abort_run("result.valid without a retire step");
        if (idle > 100) abort_run("no retire step issued for 100 cycles");
      end else begin
        idle   = 0;
        want   = exp_q.pop_front();
        at     = at_q.pop_front();
        idx    = idx_q.pop_front();
        waited = 0;
        @(negedge clk);
        while (result.valid !== 1'b1) begin
          waited++;
          if (waited >= 10) abort_run("timeout waiting for result.valid");
          @(negedge clk);
        end
        check_field("result.valid edge", 32'(cyc), 32'(at + 2));
        check_field("result.has_event", 32'(result.has_event), 32'(want.has_event));
        check_field("result.bank", 32'(result.bank), 32'(want.bank));
        check_field("result.kind", 32'(result.kind), 32'(want.kind));
        check_field("result.cause", 32'(result.cause), 32'(want.cause));
        check_field("result.target", 32'(result.target), 32'(want.target));
        check_field("table has_event", 32'(result.has_event), 32'(tab[idx].exp_event));
        check_field("table bank", 32'(result.bank), 32'(tab[idx].exp_bank));
        check_field("table kind", 32'(result.kind), 32'(tab[idx].exp_kind));
      end
    end
    $display("Regression passed");
    $finish;
  end

endmodule

/* vlog.f */
except_pkg.sv
except_bank.sv
except_ram.sv
except_writeback.sv
except_retire.sv
except_top.sv
tb_clock.sv
tb_except.sv

/* Makefile */
# Verilator lint, simulation and clean for the event RAM subsystem.

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module except_top
	verilator --lint-only --timing -f vlog.f --top-module tb_except

# pass only when the run prints the pass line.
sim:
	verilator --binary --timing -f vlog.f --top-module tb_except
	./obj_dir/Vtb_except | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir
